/* logic/imu_i2c_pkg.sv */
//////////////////////////////////////////////////
// shared types and constants for the IMU I2C master
// rate table assumes i2c_clk cycles per quarter bit
//////////////////////////////////////////////////
package imu_i2c_pkg;

	// bus and sensor constants
	localparam logic [6:0] SENSOR_DEV_ADDR = 7'h6A;  // SA0 tied low
	localparam logic [7:0] OUT_TEMP_L_ADDR = 8'h20;  // first output register
	localparam int         BURST_BYTES     = 14;
	localparam int         SAMPLE_WORDS    = 7;      // temp, gyro xyz, accel xyz

	// rate code selects i2c_clk cycles per quarter bit
	localparam int RATE_W = 2;
	localparam logic [7:0] QUARTER_CYCLES [4] = '{
		8'd2,   // code 0, fastest
		8'd4,
		8'd8,
		8'd16   // code 3, slowest
	};

	typedef enum logic {
		op_cpu_write = 1'b0,  // one register write
		op_hw_stream = 1'b1   // drdy driven burst read
	} op_mode_e;

	// commands from the sequencer to the bit engine
	typedef enum logic [2:0] {
		cmd_start     = 3'd0,
		cmd_stop      = 3'd1,
		cmd_write     = 3'd2,
		cmd_read_ack  = 3'd3,
		cmd_read_nack = 3'd4
	} byte_cmd_e;

	typedef enum logic [3:0] {
		s_idle     = 4'd0,
		s_start    = 4'd1,
		s_dev_addr = 4'd2,
		s_reg_addr = 4'd3,
		s_w_data   = 4'd4,
		s_read     = 4'd5,
		s_stop     = 4'd6
	} seq_state_e;

	// one sensor word, two's complement
	typedef logic signed [15:0] sample_t;

endpackage

/* logic/i2c_bit_timer.sv */
//////////////////////////////////////////////////
// quarter bit strobes, rate taken while not running
//////////////////////////////////////////////////
module i2c_bit_timer (
	input  logic                            i2c_clk,
	input  logic                            i_rst_n,
	input  logic                            i_run,
	input  logic [imu_i2c_pkg::RATE_W-1:0] i_rate,
	output logic                            o_qtr_tick,
	output logic [1:0]                      o_phase
);

	logic [imu_i2c_pkg::RATE_W-1:0] rate_q;
	logic [7:0] cnt;
	logic [7:0] cnt_last;

	assign cnt_last = imu_i2c_pkg::QUARTER_CYCLES[rate_q] - 8'd1;

	// tick marks the end of the quarter shown on o_phase
	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rate_q     <= '0;
			cnt        <= '0;
			o_qtr_tick <= 1'b0;
			o_phase    <= 2'd0;
		end else if (!i_run) begin
			rate_q     <= i_rate;  // idle between commands
			cnt        <= '0;
			o_qtr_tick <= 1'b0;
			o_phase    <= 2'd0;
		end else begin
			o_qtr_tick <= (cnt == cnt_last);
			if (cnt == cnt_last)
				cnt <= '0;
			else
				cnt <= cnt + 8'd1;
			if (o_qtr_tick)
				o_phase <= o_phase + 2'd1;
		end
	end

	// the shifter drops run right after the last tick of a command
	a_no_tick_idle: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		!i_run |-> !o_qtr_tick);

endmodule

/* logic/i2c_byte_shifter.sv */
//////////////////////////////////////////////////
// open drain outputs only, pad tristates sit outside
// SCL stays held low between commands until stop
//////////////////////////////////////////////////
module i2c_byte_shifter (
	input  logic                   i2c_clk,
	input  logic                   i_rst_n,
	input  logic                   i_cmd_valid,
	input  imu_i2c_pkg::byte_cmd_e i_cmd,
	input  logic [7:0]             i_tx_byte,
	input  logic                   i_qtr_tick,
	input  logic [1:0]             i_phase,
	input  logic                   i_sda,
	output logic                   o_run,
	output logic                   o_busy,
	output logic                   o_done,
	output logic                   o_ack_ok,
	output logic [7:0]             o_rx_byte,
	output logic                   o_rx_valid,
	output logic                   o_scl_low,
	output logic                   o_sda_low
);

	imu_i2c_pkg::byte_cmd_e cmd_q;
	logic       active;
	logic [3:0] bit_cnt;
	logic [7:0] shreg;
	logic       is_byte;
	logic       last_bit;
	logic       drive_bit;
	logic       sample_pt;
	logic       bit_end;

	assign is_byte   = (cmd_q != imu_i2c_pkg::cmd_start) && (cmd_q != imu_i2c_pkg::cmd_stop);
	assign last_bit  = (bit_cnt == 4'd8);  // ninth bit is ACK
	assign sample_pt = active && i_qtr_tick && (i_phase == 2'd1);  // start of quarter 2
	assign bit_end   = active && i_qtr_tick && (i_phase == 2'd3);

	// low on SDA: data zero on writes, master ACK on reads
	assign drive_bit = last_bit ? (cmd_q == imu_i2c_pkg::cmd_read_ack)
	                            : (cmd_q == imu_i2c_pkg::cmd_write && !shreg[7]);

	assign o_run     = active;
	assign o_busy    = active;
	assign o_rx_byte = shreg;

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active     <= 1'b0;
			cmd_q      <= imu_i2c_pkg::cmd_stop;
			bit_cnt    <= 4'd0;
			o_done     <= 1'b0;
			o_rx_valid <= 1'b0;
			o_ack_ok   <= 1'b0;
			o_scl_low  <= 1'b0;
			o_sda_low  <= 1'b0;
		end else begin
			o_done     <= 1'b0;
			o_rx_valid <= 1'b0;
			if (i_cmd_valid && !active) begin
				active  <= 1'b1;
				cmd_q   <= i_cmd;
				bit_cnt <= 4'd0;
			end else if (active) begin
				case (cmd_q)
					imu_i2c_pkg::cmd_start: begin
						o_scl_low <= (i_phase == 2'd3);
						o_sda_low <= (i_phase >= 2'd2);  // SDA falls with SCL high
					end
					imu_i2c_pkg::cmd_stop: begin
						o_scl_low <= (i_phase == 2'd0);
						o_sda_low <= (i_phase <= 2'd1);  // SDA rises with SCL high
					end
					default: begin
						o_scl_low <= (i_phase == 2'd0) || (i_phase == 2'd3);
						if (i_phase == 2'd0)
							o_sda_low <= drive_bit;
					end
				endcase
				if (sample_pt && last_bit && cmd_q == imu_i2c_pkg::cmd_write)
					o_ack_ok <= !i_sda;  // slave pulls low to ACK
				if (bit_end) begin
					if (!is_byte || last_bit) begin
						active     <= 1'b0;
						o_done     <= 1'b1;
						o_rx_valid <= is_byte && (cmd_q != imu_i2c_pkg::cmd_write);
					end else begin
						bit_cnt <= bit_cnt + 4'd1;
					end
				end
			end
		end
	end

	// MSB first both ways, writes shift their own bits back in
	always_ff @(posedge i2c_clk) begin
		if (i_cmd_valid && !active)
			shreg <= i_tx_byte;
		else if (sample_pt && is_byte && !last_bit)
			shreg <= {shreg[6:0], i_sda};
	end

	a_cmd_when_idle: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		i_cmd_valid |-> !o_busy);

	// data only moves while SCL is low
	a_sda_stable: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		(!o_scl_low && !$past(o_scl_low) && is_byte) |-> $stable(o_sda_low));

endmodule

/* logic/imu_xfer_sequencer.sv */
//////////////////////////////////////////////////
// i_enable and drdy are levels, seen only in idle
//////////////////////////////////////////////////
module imu_xfer_sequencer (
	input  logic                   i2c_clk,
	input  logic                   i_rst_n,
	input  imu_i2c_pkg::op_mode_e  i_mode,
	input  logic                   i_enable,
	input  logic                   i_drdy,
	input  logic                   i_clear,
	input  logic [6:0]             i_dev_addr,
	input  logic [7:0]             i_reg_addr,
	input  logic [7:0]             i_w_data,
	input  logic                   i_done,
	input  logic                   i_ack_ok,
	input  logic                   i_busy,
	output logic                   o_cmd_valid,
	output imu_i2c_pkg::byte_cmd_e o_cmd,
	output logic [7:0]             o_tx_byte,
	output logic                   o_burst_start,
	output logic                   o_burst_commit,
	output logic                   o_finish,
	output logic                   o_ready
);

	imu_i2c_pkg::seq_state_e state;
	imu_i2c_pkg::byte_cmd_e  next_cmd;
	logic [7:0] next_tx;
	logic [3:0] rd_cnt;
	logic       drdy_s1;
	logic       drdy_s2;
	logic       clear_d;
	logic       clear_rise;
	logic       stream;    // mode taken at transaction start
	logic       rd_phase;  // second half of a stream burst
	logic       xfer_ok;
	logic       issued;
	logic       issue;
	logic       start_req;
	logic       last_rd;

	assign start_req  = (i_mode == imu_i2c_pkg::op_hw_stream) ? drdy_s2 : i_enable;
	assign issue      = (state != imu_i2c_pkg::s_idle) && !issued && !i_busy;
	assign last_rd    = (rd_cnt == 4'(imu_i2c_pkg::BURST_BYTES - 1));
	assign clear_rise = i_clear && !clear_d;
	assign o_ready    = (state == imu_i2c_pkg::s_idle);

	// command for the current step
	always_comb begin
		next_cmd = imu_i2c_pkg::cmd_write;
		next_tx  = i_w_data;
		case (state)
			imu_i2c_pkg::s_start:    next_cmd = imu_i2c_pkg::cmd_start;
			imu_i2c_pkg::s_dev_addr: next_tx  = {i_dev_addr, rd_phase};  // R/W bit
			imu_i2c_pkg::s_reg_addr: next_tx  = stream ? imu_i2c_pkg::OUT_TEMP_L_ADDR
			                                           : i_reg_addr;
			imu_i2c_pkg::s_read:     next_cmd = last_rd ? imu_i2c_pkg::cmd_read_nack
			                                            : imu_i2c_pkg::cmd_read_ack;
			imu_i2c_pkg::s_stop:     next_cmd = imu_i2c_pkg::cmd_stop;
			default: ;
		endcase
	end

	always_ff @(posedge i2c_clk) begin
		if (issue) begin
			o_cmd     <= next_cmd;
			o_tx_byte <= next_tx;
		end
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state          <= imu_i2c_pkg::s_idle;
			drdy_s1        <= 1'b0;
			drdy_s2        <= 1'b0;
			clear_d        <= 1'b0;
			stream         <= 1'b0;
			rd_phase       <= 1'b0;
			xfer_ok        <= 1'b0;
			issued         <= 1'b0;
			rd_cnt         <= 4'd0;
			o_cmd_valid    <= 1'b0;
			o_burst_start  <= 1'b0;
			o_burst_commit <= 1'b0;
			o_finish       <= 1'b0;
		end else begin
			drdy_s1        <= i_drdy;
			drdy_s2        <= drdy_s1;
			clear_d        <= i_clear;
			o_cmd_valid    <= 1'b0;
			o_burst_start  <= 1'b0;
			o_burst_commit <= 1'b0;
			if (clear_rise)
				o_finish <= 1'b0;
			if (state == imu_i2c_pkg::s_idle) begin
				if (start_req) begin
					stream   <= (i_mode == imu_i2c_pkg::op_hw_stream);
					rd_phase <= 1'b0;
					xfer_ok  <= 1'b1;
					state    <= imu_i2c_pkg::s_start;
				end
			end else if (issue) begin
				o_cmd_valid <= 1'b1;
				issued      <= 1'b1;
			end else if (i_done) begin
				issued <= 1'b0;
				case (state)
					imu_i2c_pkg::s_start: state <= imu_i2c_pkg::s_dev_addr;
					imu_i2c_pkg::s_dev_addr: begin
						if (!i_ack_ok) begin
							xfer_ok <= 1'b0;  // nobody home
							state   <= imu_i2c_pkg::s_stop;
						end else if (rd_phase) begin
							o_burst_start <= 1'b1;
							rd_cnt        <= 4'd0;
							state         <= imu_i2c_pkg::s_read;
						end else begin
							state <= imu_i2c_pkg::s_reg_addr;
						end
					end
					imu_i2c_pkg::s_reg_addr:
						state <= stream ? imu_i2c_pkg::s_stop : imu_i2c_pkg::s_w_data;
					imu_i2c_pkg::s_w_data: state <= imu_i2c_pkg::s_stop;
					imu_i2c_pkg::s_read: begin
						rd_cnt <= rd_cnt + 4'd1;
						if (last_rd)
							state <= imu_i2c_pkg::s_stop;
					end
					imu_i2c_pkg::s_stop: begin
						if (stream && !rd_phase && xfer_ok) begin
							rd_phase <= 1'b1;  // pointer set, now read back
							state    <= imu_i2c_pkg::s_start;
						end else begin
							state <= imu_i2c_pkg::s_idle;
							if (xfer_ok)
								o_finish <= 1'b1;  // wins over a clear edge
							if (xfer_ok && rd_phase)
								o_burst_commit <= 1'b1;
						end
					end
					default: state <= imu_i2c_pkg::s_idle;
				endcase
			end
		end
	end

endmodule

/* logic/imu_sample_store.sv */
//////////////////////////////////////////////////
// burst bytes arrive low byte first in register order
//////////////////////////////////////////////////
module imu_sample_store (
	input  logic                 i2c_clk,
	input  logic                 i_rst_n,
	input  logic                 i_burst_start,
	input  logic                 i_rx_valid,
	input  logic [7:0]           i_rx_byte,
	input  logic                 i_burst_commit,
	input  logic                 i_latch,
	output imu_i2c_pkg::sample_t o_temp,
	output imu_i2c_pkg::sample_t o_gyro_x,
	output imu_i2c_pkg::sample_t o_gyro_y,
	output imu_i2c_pkg::sample_t o_gyro_z,
	output imu_i2c_pkg::sample_t o_acc_x,
	output imu_i2c_pkg::sample_t o_acc_y,
	output imu_i2c_pkg::sample_t o_acc_z
);

	logic [7:0] burst_buf [imu_i2c_pkg::BURST_BYTES];
	imu_i2c_pkg::sample_t live [imu_i2c_pkg::SAMPLE_WORDS];
	logic [3:0] byte_idx;

	always_ff @(posedge i2c_clk) begin
		if (i_rx_valid)
			burst_buf[byte_idx] <= i_rx_byte;
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			byte_idx <= 4'd0;
			for (int w = 0; w < imu_i2c_pkg::SAMPLE_WORDS; w++)
				live[w] <= '0;
		end else begin
			if (i_burst_start)
				byte_idx <= 4'd0;
			else if (i_rx_valid)
				byte_idx <= byte_idx + 4'd1;
			if (i_burst_commit) begin
				for (int w = 0; w < imu_i2c_pkg::SAMPLE_WORDS; w++)
					live[w] <= {burst_buf[2*w+1], burst_buf[2*w]};  // high, low
			end
		end
	end

	// outputs only move on latch
	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_temp   <= '0;
			o_gyro_x <= '0;
			o_gyro_y <= '0;
			o_gyro_z <= '0;
			o_acc_x  <= '0;
			o_acc_y  <= '0;
			o_acc_z  <= '0;
		end else if (i_latch) begin
			o_temp   <= live[0];
			o_gyro_x <= live[1];
			o_gyro_y <= live[2];
			o_gyro_z <= live[3];
			o_acc_x  <= live[4];
			o_acc_y  <= live[5];
			o_acc_z  <= live[6];
		end
	end

	// sequencer issues exactly one burst worth of reads
	a_idx_range: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		byte_idx <= imu_i2c_pkg::BURST_BYTES);

endmodule

/* logic/imu_i2c_top.sv */
//////////////////////////////////////////////////
// pad tristates and pull-ups are external
//////////////////////////////////////////////////
module imu_i2c_top (
	input  logic                            i2c_clk,
	input  logic                            i_rst_n,
	input  imu_i2c_pkg::op_mode_e           i_mode,
	input  logic                            i_enable,
	input  logic                            i_drdy,
	input  logic                            i_clear,
	input  logic [6:0]                      i_dev_addr,
	input  logic [7:0]                      i_reg_addr,
	input  logic [7:0]                      i_w_data,
	input  logic [imu_i2c_pkg::RATE_W-1:0] i_rate,
	input  logic                            i_latch,
	input  logic                            i_sda,
	output logic                            o_scl_low,
	output logic                            o_sda_low,
	output logic                            o_finish,
	output logic                            o_ready,
	output imu_i2c_pkg::sample_t            o_temp,
	output imu_i2c_pkg::sample_t            o_gyro_x,
	output imu_i2c_pkg::sample_t            o_gyro_y,
	output imu_i2c_pkg::sample_t            o_gyro_z,
	output imu_i2c_pkg::sample_t            o_acc_x,
	output imu_i2c_pkg::sample_t            o_acc_y,
	output imu_i2c_pkg::sample_t            o_acc_z
);

	logic       run;
	logic       qtr_tick;
	logic [1:0] phase;
	logic       cmd_valid;
	logic [7:0] tx_byte;
	logic       busy;
	logic       done;
	logic       ack_ok;
	logic [7:0] rx_byte;
	logic       rx_valid;
	logic       burst_start;
	logic       burst_commit;
	imu_i2c_pkg::byte_cmd_e cmd;

	i2c_bit_timer u_timer (
		.i2c_clk    (i2c_clk),
		.i_rst_n    (i_rst_n),
		.i_run      (run),
		.i_rate     (i_rate),
		.o_qtr_tick (qtr_tick),
		.o_phase    (phase)
	);

	i2c_byte_shifter u_shifter (
		.i2c_clk     (i2c_clk),
		.i_rst_n     (i_rst_n),
		.i_cmd_valid (cmd_valid),
		.i_cmd       (cmd),
		.i_tx_byte   (tx_byte),
		.i_qtr_tick  (qtr_tick),
		.i_phase     (phase),
		.i_sda       (i_sda),
		.o_run       (run),
		.o_busy      (busy),
		.o_done      (done),
		.o_ack_ok    (ack_ok),
		.o_rx_byte   (rx_byte),
		.o_rx_valid  (rx_valid),
		.o_scl_low   (o_scl_low),
		.o_sda_low   (o_sda_low)
	);

	imu_xfer_sequencer u_seq (
		.i2c_clk        (i2c_clk),
		.i_rst_n        (i_rst_n),
		.i_mode         (i_mode),
		.i_enable       (i_enable),
		.i_drdy         (i_drdy),
		.i_clear        (i_clear),
		.i_dev_addr     (i_dev_addr),
		.i_reg_addr     (i_reg_addr),
		.i_w_data       (i_w_data),
		.i_done         (done),
		.i_ack_ok       (ack_ok),
		.i_busy         (busy),
		.o_cmd_valid    (cmd_valid),
		.o_cmd          (cmd),
		.o_tx_byte      (tx_byte),
		.o_burst_start  (burst_start),
		.o_burst_commit (burst_commit),
		.o_finish       (o_finish),
		.o_ready        (o_ready)
	);

	imu_sample_store u_store (
		.i2c_clk        (i2c_clk),
		.i_rst_n        (i_rst_n),
		.i_burst_start  (burst_start),
		.i_rx_valid     (rx_valid),
		.i_rx_byte      (rx_byte),
		.i_burst_commit (burst_commit),
		.i_latch        (i_latch),
		.o_temp         (o_temp),
		.o_gyro_x       (o_gyro_x),
		.o_gyro_y       (o_gyro_y),
		.o_gyro_z       (o_gyro_z),
		.o_acc_x        (o_acc_x),
		.o_acc_y        (o_acc_y),
		.o_acc_z        (o_acc_z)
	);

endmodule

/* testbench/imu_slave_model.sv */
//////////////////////////////////////////////////
// behavioral sensor, no clock stretching, no repeated start
//////////////////////////////////////////////////
module imu_slave_model #(
	parameter logic [6:0] DEV_ADDR = imu_i2c_pkg::SENSOR_DEV_ADDR
) (
	input  logic         i_scl,
	input  logic         i_sda,
	input  logic [111:0] i_rd_data,  // byte 0 in the low bits
	output logic         o_sda_low
);
	timeunit 1ns;
	timeprecision 1ps;

	logic        active;
	logic        first;      // address byte of this transaction
	logic        addressed;
	logic        tx_on;      // slave sends read bytes
	logic        last_nack;
	logic [7:0]  shreg;
	logic [7:0]  tx_byte;
	logic [7:0]  wr_log [16];
	logic [13:0] ack_map;    // master ACK per read byte
	int          bit_cnt;
	int          rd_idx;
	int          wr_cnt;

	task automatic clear_log();
		wr_cnt  = 0;
		rd_idx  = 0;
		ack_map = '0;
	endtask

	initial begin
		o_sda_low = 1'b0;
		active    = 1'b0;
		first     = 1'b0;
		addressed = 1'b0;
		tx_on     = 1'b0;
		last_nack = 1'b0;
		shreg     = '0;
		bit_cnt   = 0;
		clear_log();
	end

	// start, SDA falls with SCL high
	always @(negedge i_sda) begin
		if (i_scl === 1'b1 && i_sda === 1'b0) begin
			active    = 1'b1;
			first     = 1'b1;
			addressed = 1'b0;
			tx_on     = 1'b0;
			bit_cnt   = 0;
			o_sda_low = 1'b0;
		end
	end

	// stop, SDA rises with SCL high
	always @(posedge i_sda) begin
		if (i_scl === 1'b1 && i_sda === 1'b1) begin
			active    = 1'b0;
			tx_on     = 1'b0;
			o_sda_low = 1'b0;
		end
	end

	always @(posedge i_scl) begin
		if (active) begin
			if (bit_cnt < 8) begin
				shreg = {shreg[6:0], i_sda};
			end else if (tx_on && rd_idx < 14) begin
				ack_map[rd_idx] = !i_sda;  // master ACK slot
				last_nack       = i_sda;
				rd_idx++;
			end
			bit_cnt++;
		end
	end

	always @(negedge i_scl) begin
		if (active) begin
			if (bit_cnt == 8) begin
				if (tx_on) begin
					o_sda_low = 1'b0;  // let the master answer
				end else if (first) begin
					addressed = (shreg[7:1] == DEV_ADDR);
					if (addressed && wr_cnt < 16)
						wr_log[wr_cnt++] = shreg;
					o_sda_low = addressed;
				end else if (addressed) begin
					if (wr_cnt < 16)
						wr_log[wr_cnt++] = shreg;
					o_sda_low = 1'b1;
				end
			end else if (bit_cnt == 9) begin
				bit_cnt   = 0;
				o_sda_low = 1'b0;
				if (first && addressed && shreg[0]) begin
					tx_on     = 1'b1;
					last_nack = 1'b0;
				end
				first = 1'b0;
				if (tx_on && !last_nack && rd_idx < 14) begin
					tx_byte   = i_rd_data[rd_idx*8 +: 8];
					o_sda_low = !tx_byte[7];
				end
			end else if (tx_on && !last_nack && bit_cnt >= 1) begin
				o_sda_low = !tx_byte[7-bit_cnt];  // MSB first
			end
		end
	end

endmodule

/* testbench/tb_imu_i2c.sv */
//////////////////////////////////////////////////
// one golden line per test, run from the project root
//////////////////////////////////////////////////
module tb_imu_i2c;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int FIELDS    = 26;  // mode rate dev reg data, 14 bytes, 7 words
	localparam int MAX_TESTS = 8;

	logic                  i2c_clk;
	logic                  i_rst_n;
	imu_i2c_pkg::op_mode_e i_mode;
	logic                  i_enable;
	logic                  i_drdy;
	logic                  i_clear;
	logic                  i_latch;
	logic [6:0]            i_dev_addr;
	logic [7:0]            i_reg_addr;
	logic [7:0]            i_w_data;
	logic [1:0]            i_rate;
	logic                  o_scl_low;
	logic                  o_sda_low;
	logic                  o_finish;
	logic                  o_ready;
	imu_i2c_pkg::sample_t  o_temp;
	imu_i2c_pkg::sample_t  o_gyro_x;
	imu_i2c_pkg::sample_t  o_gyro_y;
	imu_i2c_pkg::sample_t  o_gyro_z;
	imu_i2c_pkg::sample_t  o_acc_x;
	imu_i2c_pkg::sample_t  o_acc_y;
	imu_i2c_pkg::sample_t  o_acc_z;
	logic                  slave_sda_low;
	logic [111:0]          rd_data;
	tri1                   scl_bus;
	tri1                   sda_bus;

	logic [15:0]          golden [FIELDS*MAX_TESTS];
	imu_i2c_pkg::sample_t held [7];  // what the outputs should show
	int                   errors;
	int                   test_errors;
	int                   n_tests;
	int                   high_run;
	int                   last_high;
	longint               limit_ns;
	logic                 limit_set;

	// open drain, both sides only pull low
	assign scl_bus = o_scl_low ? 1'b0 : 1'bz;
	assign sda_bus = o_sda_low ? 1'b0 : 1'bz;
	assign sda_bus = slave_sda_low ? 1'b0 : 1'bz;

	imu_i2c_top u_dut (
		.i2c_clk(i2c_clk), .i_rst_n(i_rst_n), .i_mode(i_mode),
		.i_enable(i_enable), .i_drdy(i_drdy), .i_clear(i_clear),
		.i_dev_addr(i_dev_addr), .i_reg_addr(i_reg_addr), .i_w_data(i_w_data),
		.i_rate(i_rate), .i_latch(i_latch), .i_sda(sda_bus),
		.o_scl_low(o_scl_low), .o_sda_low(o_sda_low),
		.o_finish(o_finish), .o_ready(o_ready),
		.o_temp(o_temp), .o_gyro_x(o_gyro_x), .o_gyro_y(o_gyro_y),
		.o_gyro_z(o_gyro_z), .o_acc_x(o_acc_x), .o_acc_y(o_acc_y), .o_acc_z(o_acc_z)
	);

	imu_slave_model u_slave (
		.i_scl(scl_bus), .i_sda(sda_bus), .i_rd_data(rd_data), .o_sda_low(slave_sda_low)
	);

	initial begin
		i2c_clk = 1'b0;
		forever #50 i2c_clk = ~i2c_clk;
	end

	// length of the last SCL high pulse in clock cycles
	always @(negedge i2c_clk) begin
		if (scl_bus === 1'b1) begin
			high_run++;
		end else if (high_run != 0) begin
			last_high = high_run;
			high_run  = 0;
		end
	end

	initial begin
		wait (limit_set);
		#(limit_ns);
		$display("timeout: a transaction did not finish after %0d ns", limit_ns);
		$display("=== FAIL ===");
		$finish;
	end

	function automatic imu_i2c_pkg::sample_t out_word(input int w);
		case (w)
			0: return o_temp;
			1: return o_gyro_x;
			2: return o_gyro_y;
			3: return o_gyro_z;
			4: return o_acc_x;
			5: return o_acc_y;
			default: return o_acc_z;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("error: %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic pulse_latch();
		@(negedge i2c_clk);
		i_latch = 1'b1;
		@(negedge i2c_clk);
		i_latch = 1'b0;
	endtask

	task automatic check_outputs(input string tag);
		for (int w = 0; w < 7; w++)
			check($sformatf("%s word %0d", tag, w), 32'(out_word(w)), 32'(held[w]));
	endtask

	task automatic run_test(input int t);
		int    base;
		int    rate;
		string kind;
		logic  stream;
		logic  nack;
		base        = t * FIELDS;
		test_errors = 0;
		rate        = golden[base+1][1:0];
		stream      = golden[base][0];
		nack        = (golden[base+2][6:0] != imu_i2c_pkg::SENSOR_DEV_ADDR);
		@(negedge i2c_clk);
		i_mode     = imu_i2c_pkg::op_mode_e'(golden[base][0]);
		i_rate     = golden[base+1][1:0];
		i_dev_addr = golden[base+2][6:0];
		i_reg_addr = golden[base+3][7:0];
		i_w_data   = golden[base+4][7:0];
		for (int b = 0; b < 14; b++)
			rd_data[b*8 +: 8] = golden[base+5+b][7:0];
		u_slave.clear_log();
		i_clear = 1'b1;  // rising edge clears finish, then stays high
		repeat (3) @(negedge i2c_clk);
		check("o_finish", o_finish, 0);
		if (stream)
			i_drdy = 1'b1;
		else
			i_enable = 1'b1;
		while (o_ready)
			@(negedge i2c_clk);
		i_drdy   = 1'b0;
		i_enable = 1'b0;
		while (!o_ready)
			@(negedge i2c_clk);
		repeat (3) @(negedge i2c_clk);
		check("scl high cycles", last_high, 4 << rate);  // 2 quarters of 2 << rate
		check("o_ready", o_ready, 1);
		if (nack) begin
			kind = "address nack";
			check("o_finish", o_finish, 0);
			check("slave bytes", u_slave.wr_cnt, 0);
			pulse_latch();
			check_outputs("held");
		end else if (!stream) begin
			kind = "cpu write";
			check("o_finish", o_finish, 1);
			check("slave bytes", u_slave.wr_cnt, 3);
			check("address byte", u_slave.wr_log[0], {i_dev_addr, 1'b0});
			check("register", u_slave.wr_log[1], i_reg_addr);
			check("data", u_slave.wr_log[2], i_w_data);
		end else begin
			kind = "stream burst";
			check("o_finish", o_finish, 1);
			check("slave bytes", u_slave.wr_cnt, 3);
			check("address byte", u_slave.wr_log[0], {i_dev_addr, 1'b0});
			check("pointer", u_slave.wr_log[1], imu_i2c_pkg::OUT_TEMP_L_ADDR);
			check("read address", u_slave.wr_log[2], {i_dev_addr, 1'b1});
			check("bytes read", u_slave.rd_idx, 14);
			check("ack map", u_slave.ack_map, 14'h1fff);  // last byte NACKed
			check_outputs("before latch");
			pulse_latch();
			for (int w = 0; w < 7; w++) begin
				held[w] = golden[base+19+w];
				check($sformatf("byte pair %0d", w), 32'(out_word(w)),
					32'($signed({rd_data[(2*w+1)*8 +: 8], rd_data[2*w*8 +: 8]})));
			end
			check_outputs("after latch");
		end
		check("o_finish held", o_finish, nack ? 0 : 1);
		i_clear = 1'b0;
		$display("test %0d %s rate %0d: %s", t, kind, rate, test_errors ? "failed" : "ok");
		errors += test_errors;
	endtask

	initial begin
		i_rst_n    = 1'b0;
		i_mode     = imu_i2c_pkg::op_cpu_write;
		i_enable   = 1'b0;
		i_drdy     = 1'b0;
		i_clear    = 1'b0;
		i_latch    = 1'b0;
		i_dev_addr = imu_i2c_pkg::SENSOR_DEV_ADDR;
		i_reg_addr = '0;
		i_w_data   = '0;
		i_rate     = '0;
		rd_data    = '0;
		errors     = 0;
		high_run   = 0;
		last_high  = 0;
		limit_set  = 1'b0;
		limit_ns   = 10_000;
		for (int w = 0; w < 7; w++)
			held[w] = '0;
		$readmemh("testbench/imu_golden.txt", golden);
		n_tests = 0;
		while (n_tests < MAX_TESTS && !$isunknown(golden[n_tests*FIELDS]))
			n_tests++;
		// 40 bits of 64 cycles per transaction and two transactions per burst
		for (int t = 0; t < n_tests; t++)
			limit_ns += (golden[t*FIELDS][0] ? 80 : 40) * 64 * 100 * 2;
		limit_set = 1'b1;
		repeat (2) @(negedge i2c_clk);
		i_rst_n = 1'b1;
		@(negedge i2c_clk);
		test_errors = 0;
		check("o_scl_low", o_scl_low, 0);
		check("o_sda_low", o_sda_low, 0);
		check("o_finish", o_finish, 0);
		check("o_ready", o_ready, 1);
		check_outputs("reset");
		$display("test reset state: %s", test_errors ? "failed" : "ok");
		errors += test_errors;
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("tests %0d, errors %0d", n_tests, errors);
		if (errors == 0 && n_tests > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* testbench/imu_golden.txt */
// mode rate dev_addr reg data, slave bytes b0..b13, expected words temp gx gy gz ax ay az
// mode 0 cpu write, 1 stream; a dev_addr other than 6A expects an address NACK
0 0 6A 10 5C 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0000 0000 0000 0000 0000 0000 0000
1 1 6A 00 00 34 12 CD AB 78 56 01 80 FF 7F 00 00 AA 55 1234 ABCD 5678 8001 7FFF 0000 55AA
1 0 6A 00 00 10 FE 20 00 30 FF 40 01 50 FE 60 02 70 FD FE10 0020 FF30 0140 FE50 0260 FD70
0 2 35 11 22 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0000 0000 0000 0000 0000 0000 0000
0 3 6A 1F A5 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0000 0000 0000 0000 0000 0000 0000
1 3 6A 00 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0201 0403 0605 0807 0A09 0C0B 0E0D

/* verilog.f */
logic/imu_i2c_pkg.sv
logic/i2c_bit_timer.sv
logic/i2c_byte_shifter.sv
logic/imu_xfer_sequencer.sv
logic/imu_sample_store.sv
logic/imu_i2c_top.sv
testbench/imu_slave_model.sv
testbench/tb_imu_i2c.sv

/* Bender.yml */
package:
  name: imu_i2c

sources:
  - logic/imu_i2c_pkg.sv
  - logic/i2c_bit_timer.sv
  - logic/i2c_byte_shifter.sv
  - logic/imu_xfer_sequencer.sv
  - logic/imu_sample_store.sv
  - logic/imu_i2c_top.sv
  - target: test
    files:
      - testbench/imu_slave_model.sv
      - testbench/tb_imu_i2c.sv
